/* include/ppu_video_cfg.svh */
`ifndef PPU_VIDEO_CFG_SVH
`define PPU_VIDEO_CFG_SVH

// ******************************
// 640x480 @ 60 Hz raster timing
// ******************************
`define PPU_H_SYNC   96     // pixel clocks
`define PPU_H_BACK   48
`define PPU_H_DISP   640
`define PPU_H_FRONT  16
`define PPU_H_TOTAL  800

`define PPU_V_SYNC   2      // lines
`define PPU_V_BACK   33
`define PPU_V_DISP   480
`define PPU_V_FRONT  10
`define PPU_V_TOTAL  525

// ******************************
// game window and frame size
// ******************************
`define PPU_WIN_X0   64     // window is 2*PPU_FB_W wide, full height
`define PPU_FB_W     256
`define PPU_FB_H     240
`define PPU_BORDER_RGB 24'h002010

`endif

/* source/ppu_video_pkg.sv */
package ppu_video_pkg;

    // ******************************
    // pixel and coordinate words
    // ******************************

    // screen coordinate, also wide enough for the raster counters
    typedef logic [11:0] coord_t;

    typedef logic [5:0]  nes_color_t;   // nes palette index
    typedef logic [15:0] rgb565_t;      // r5 g6 b5
    typedef logic [23:0] rgb888_t;      // r8 g8 b8

    // nes y * 256 + nes x
    typedef logic [15:0] fb_addr_t;

    // ******************************
    // raster axis state
    // ******************************
    typedef enum logic [1:0] {
        REGION_SYNC,
        REGION_BACK,
        REGION_ACTIVE,
        REGION_FRONT
    } raster_region_e;

endpackage

/* source/pixel_bus_if.sv */
`timescale 1ns/1ps

interface pixel_bus_if;

    ppu_video_pkg::coord_t  pixel_xpos;     // valid while data_req is high
    ppu_video_pkg::coord_t  pixel_ypos;
    logic                   data_req;
    ppu_video_pkg::rgb565_t video_rgb_565;  // one cycle after data_req
    logic                   in_window;

    modport driver (
        output pixel_xpos, pixel_ypos, data_req,
        input  video_rgb_565, in_window
    );

    modport source (
        input  pixel_xpos, pixel_ypos, data_req,
        output video_rgb_565, in_window
    );

endinterface

/* source/nes_palette.sv */
`timescale 1ns/1ps

module nes_palette (
    input  ppu_video_pkg::nes_color_t index,
    output ppu_video_pkg::rgb565_t    rgb
);

    // 2C02 master palette, truncated to rgb565
    // unlisted entries ($0D-$0F, $1D-$1F, $2E-$2F, $3E-$3F) are black
    always_comb begin
        case (index)
            6'h00: rgb = 16'h7BEF;
            6'h01: rgb = 16'h001F;
            6'h02: rgb = 16'h0017;
            6'h03: rgb = 16'h4157;
            6'h04: rgb = 16'h9010;
            6'h05: rgb = 16'hA804;
            6'h06: rgb = 16'hA880;
            6'h07: rgb = 16'h88A0;
            6'h08: rgb = 16'h5180;
            6'h09: rgb = 16'h03C0;
            6'h0A: rgb = 16'h0340;
            6'h0B: rgb = 16'h02C0;
            6'h0C: rgb = 16'h020B;
            6'h10: rgb = 16'hBDF7;  // second row, brighter
            6'h11: rgb = 16'h03DF;
            6'h12: rgb = 16'h02DF;
            6'h13: rgb = 16'h6A3F;
            6'h14: rgb = 16'hD819;
            6'h15: rgb = 16'hE00B;
            6'h16: rgb = 16'hF9C0;
            6'h17: rgb = 16'hE2E2;
            6'h18: rgb = 16'hABE0;
            6'h19: rgb = 16'h05C0;
            6'h1A: rgb = 16'h0540;
            6'h1B: rgb = 16'h0548;
            6'h1C: rgb = 16'h0451;
            6'h20: rgb = 16'hFFDF;
            6'h21: rgb = 16'h3DFF;
            6'h22: rgb = 16'h6C5F;
            6'h23: rgb = 16'h9BDF;
            6'h24: rgb = 16'hFBDF;
            6'h25: rgb = 16'hFAD3;
            6'h26: rgb = 16'hFBCB;
            6'h27: rgb = 16'hFD08;
            6'h28: rgb = 16'hFDC0;
            6'h29: rgb = 16'hBFC3;
            6'h2A: rgb = 16'h5ECA;
            6'h2B: rgb = 16'h5FD3;
            6'h2C: rgb = 16'h075B;
            6'h2D: rgb = 16'h7BCF;  // dark grey
            6'h30: rgb = 16'hFFFF;  // pastel row
            6'h31: rgb = 16'hA73F;
            6'h32: rgb = 16'hBDDF;
            6'h33: rgb = 16'hDDDF;
            6'h34: rgb = 16'hFDDF;
            6'h35: rgb = 16'hFD38;
            6'h36: rgb = 16'hF696;
            6'h37: rgb = 16'hFF15;
            6'h38: rgb = 16'hFECF;
            6'h39: rgb = 16'hDFCF;
            6'h3A: rgb = 16'hBFD7;
            6'h3B: rgb = 16'hBFDB;
            6'h3C: rgb = 16'h07FF;
            6'h3D: rgb = 16'hFEDF;
            default: rgb = 16'h0000;
        endcase
    end

endmodule

/* source/ppu_frame_buffer.sv */
`timescale 1ns/1ps
`include "ppu_video_cfg.svh"

module ppu_frame_buffer (
    input  logic                      pixel_clk,
    input  logic                      we,
    input  ppu_video_pkg::fb_addr_t   waddr,
    input  ppu_video_pkg::nes_color_t wdata,
    input  ppu_video_pkg::fb_addr_t   raddr,
    output ppu_video_pkg::nes_color_t rdata
);

    localparam int unsigned FB_DEPTH = `PPU_FB_W * `PPU_FB_H;  // 61440 cells

    ppu_video_pkg::nes_color_t mem [0:FB_DEPTH-1];

    // ******************************
    // write port, ppu side
    // ******************************
    always_ff @(posedge pixel_clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ******************************
    // read port, raster side
    // ******************************

    // registered read, index valid the cycle after raddr
    always_ff @(posedge pixel_clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* source/ppu_pixel_fetch.sv */
`timescale 1ns/1ps
`include "ppu_video_cfg.svh"

module ppu_pixel_fetch (
    input  logic                      pixel_clk,
    input  logic                      sys_rst_n,
    pixel_bus_if.source               pix,
    input  logic                      ppu_we,
    input  logic [7:0]                ppu_x,
    input  logic [7:0]                ppu_y,
    input  ppu_video_pkg::nes_color_t ppu_color
);

    localparam ppu_video_pkg::coord_t WIN_X0 = ppu_video_pkg::coord_t'(`PPU_WIN_X0);
    localparam ppu_video_pkg::coord_t WIN_X1 =
        ppu_video_pkg::coord_t'(`PPU_WIN_X0 + 2 * `PPU_FB_W);  // first column past window

    logic                      in_win_req;
    ppu_video_pkg::coord_t     win_x;
    logic [7:0]                nes_x;
    logic [7:0]                nes_y;
    ppu_video_pkg::fb_addr_t   raddr;
    ppu_video_pkg::fb_addr_t   waddr;
    ppu_video_pkg::nes_color_t rd_index;
    logic                      in_win_q;

    // ******************************
    // screen -> nes coordinates
    // ******************************
    assign in_win_req = pix.data_req &&
                        (pix.pixel_xpos >= WIN_X0) && (pix.pixel_xpos < WIN_X1);

    assign win_x = pix.pixel_xpos - WIN_X0;
    assign nes_x = win_x[8:1];              // each game pixel is 2 wide
    assign nes_y = pix.pixel_ypos[8:1];     // and 2 tall

    // y*256 + x, frame width is a power of two
    assign raddr = {nes_y, nes_x};
    assign waddr = {ppu_y, ppu_x};

    // window flag follows the ram read by one cycle
    always_ff @(posedge pixel_clk) begin
        if (!sys_rst_n)
            in_win_q <= 1'b0;
        else
            in_win_q <= in_win_req;
    end

    assign pix.in_window = in_win_q;

    ppu_frame_buffer ppu_frame_buffer_i (
        .pixel_clk (pixel_clk),
        .we        (ppu_we),
        .waddr     (waddr),
        .wdata     (ppu_color),
        .raddr     (raddr),
        .rdata     (rd_index)
    );

    nes_palette nes_palette_i (
        .index (rd_index),
        .rgb   (pix.video_rgb_565)
    );

endmodule

/* source/ppu_video_driver.sv */
`timescale 1ns/1ps
`include "ppu_video_cfg.svh"

module ppu_video_driver (
    input  logic                   pixel_clk,
    input  logic                   sys_rst_n,
    pixel_bus_if.driver            pix,
    output logic                   video_hs,
    output logic                   video_vs,
    output logic                   video_de,
    output ppu_video_pkg::rgb888_t video_rgb
);

    localparam ppu_video_pkg::coord_t H_SYNC_END = ppu_video_pkg::coord_t'(`PPU_H_SYNC);
    localparam ppu_video_pkg::coord_t H_ACT_START =
        ppu_video_pkg::coord_t'(`PPU_H_SYNC + `PPU_H_BACK);
    localparam ppu_video_pkg::coord_t H_ACT_END = H_ACT_START + `PPU_H_DISP;
    localparam ppu_video_pkg::coord_t H_LAST = ppu_video_pkg::coord_t'(`PPU_H_TOTAL - 1);
    localparam ppu_video_pkg::coord_t H_REQ_START = H_ACT_START - 1'b1;  // one clock early
    localparam ppu_video_pkg::coord_t H_REQ_END = H_ACT_END - 1'b1;

    localparam ppu_video_pkg::coord_t V_SYNC_END = ppu_video_pkg::coord_t'(`PPU_V_SYNC);
    localparam ppu_video_pkg::coord_t V_ACT_START =
        ppu_video_pkg::coord_t'(`PPU_V_SYNC + `PPU_V_BACK);
    localparam ppu_video_pkg::coord_t V_ACT_END = V_ACT_START + `PPU_V_DISP;
    localparam ppu_video_pkg::coord_t V_LAST = ppu_video_pkg::coord_t'(`PPU_V_TOTAL - 1);

    ppu_video_pkg::coord_t         cnt_h;
    ppu_video_pkg::coord_t         cnt_v;
    ppu_video_pkg::coord_t         cnt_h_nxt;
    ppu_video_pkg::coord_t         cnt_v_nxt;
    ppu_video_pkg::raster_region_e h_region;
    ppu_video_pkg::raster_region_e v_region;
    ppu_video_pkg::rgb888_t        rgb_wide;

    // region of one axis for a given count
    function automatic ppu_video_pkg::raster_region_e region_of(
        input ppu_video_pkg::coord_t cnt,
        input ppu_video_pkg::coord_t sync_end,
        input ppu_video_pkg::coord_t act_start,
        input ppu_video_pkg::coord_t act_end
    );
        if (cnt < sync_end)
            return ppu_video_pkg::REGION_SYNC;
        else if (cnt < act_start)
            return ppu_video_pkg::REGION_BACK;
        else if (cnt < act_end)
            return ppu_video_pkg::REGION_ACTIVE;
        else
            return ppu_video_pkg::REGION_FRONT;
    endfunction

    // ******************************
    // raster counters
    // ******************************
    always_comb begin
        cnt_h_nxt = (cnt_h == H_LAST) ? '0 : cnt_h + 1'b1;
        cnt_v_nxt = cnt_v;
        if (cnt_h == H_LAST) begin  // line wraps, step the frame
            cnt_v_nxt = (cnt_v == V_LAST) ? '0 : cnt_v + 1'b1;
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (!sys_rst_n) begin
            cnt_h    <= '0;
            cnt_v    <= '0;
            h_region <= ppu_video_pkg::REGION_SYNC;
            v_region <= ppu_video_pkg::REGION_SYNC;
        end else begin
            cnt_h    <= cnt_h_nxt;
            cnt_v    <= cnt_v_nxt;
            h_region <= region_of(cnt_h_nxt, H_SYNC_END, H_ACT_START, H_ACT_END);
            v_region <= region_of(cnt_v_nxt, V_SYNC_END, V_ACT_START, V_ACT_END);
        end
    end

    // ******************************
    // sync, enable, request
    // ******************************
    assign video_hs = (h_region != ppu_video_pkg::REGION_SYNC);  // active low
    assign video_vs = (v_region != ppu_video_pkg::REGION_SYNC);
    assign video_de = (h_region == ppu_video_pkg::REGION_ACTIVE) &&
                      (v_region == ppu_video_pkg::REGION_ACTIVE);

    assign pix.data_req = (v_region == ppu_video_pkg::REGION_ACTIVE) &&
                          (cnt_h >= H_REQ_START) && (cnt_h < H_REQ_END);

    assign pix.pixel_xpos = pix.data_req ? cnt_h - H_REQ_START : '0;  // 0..639
    assign pix.pixel_ypos = pix.data_req ? cnt_v - V_ACT_START : '0;  // 0..479

    // rgb565 -> rgb888, zero fill low bits
    assign rgb_wide = {pix.video_rgb_565[15:11], 3'b000,
                       pix.video_rgb_565[10:5],  2'b00,
                       pix.video_rgb_565[4:0],   3'b000};

    assign video_rgb = video_de ? (pix.in_window ? rgb_wide : `PPU_BORDER_RGB) : '0;

endmodule

/* source/ppu_video_top.sv */
`timescale 1ns/1ps

module ppu_video_top (
    input  logic                      pixel_clk,
    input  logic                      sys_rst_n,
    input  logic                      ppu_we,       // ppu write port
    input  logic [7:0]                ppu_x,
    input  logic [7:0]                ppu_y,
    input  ppu_video_pkg::nes_color_t ppu_color,
    output logic                      video_hs,     // towards the dvi encoder
    output logic                      video_vs,
    output logic                      video_de,
    output ppu_video_pkg::rgb888_t    video_rgb
);

    pixel_bus_if pix_bus ();

    ppu_video_driver ppu_video_driver_i (
        .pixel_clk (pixel_clk),
        .sys_rst_n (sys_rst_n),
        .pix       (pix_bus),
        .video_hs  (video_hs),
        .video_vs  (video_vs),
        .video_de  (video_de),
        .video_rgb (video_rgb)
    );

    ppu_pixel_fetch ppu_pixel_fetch_i (
        .pixel_clk (pixel_clk),
        .sys_rst_n (sys_rst_n),
        .pix       (pix_bus),
        .ppu_we    (ppu_we),
        .ppu_x     (ppu_x),
        .ppu_y     (ppu_y),
        .ppu_color (ppu_color)
    );

endmodule

/* verif/tb_ppu_video.sv */
`timescale 1ns/1ps
`include "ppu_video_cfg.svh"

module tb_ppu_video;

    localparam int FRAME_CYCLES = `PPU_H_TOTAL * `PPU_V_TOTAL;
    localparam int TIMEOUT_CYCLES = FRAME_CYCLES * 22 / 10;  // 2.2 frames

    logic                      pixel_clk;
    logic                      sys_rst_n;
    logic                      ppu_we;
    logic [7:0]                ppu_x;
    logic [7:0]                ppu_y;
    ppu_video_pkg::nes_color_t ppu_color;
    logic                      video_hs;
    logic                      video_vs;
    logic                      video_de;
    ppu_video_pkg::rgb888_t    video_rgb;

    logic [21:0]               w_rec [$];      // {x, y, index}
    ppu_video_pkg::rgb888_t    exp_rgb [int];  // key is y*640+x
    int   errors = 0;
    int   checks = 0;
    int   cycles = 0;
    int   c_hits = 0;
    int   frames = 0;
    int   line_cyc = 0;
    int   frame_cyc = 0;
    int   hs_low = 0;
    int   vs_low = 0;
    int   de_x = 0;
    int   de_row = 0;
    logic mon_on = 1'b0;
    logic reset_done = 1'b0;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic de_prev = 1'b0;

    ppu_video_top ppu_video_top_i (
        .pixel_clk (pixel_clk),
        .sys_rst_n (sys_rst_n),
        .ppu_we    (ppu_we),
        .ppu_x     (ppu_x),
        .ppu_y     (ppu_y),
        .ppu_color (ppu_color),
        .video_hs  (video_hs),
        .video_vs  (video_vs),
        .video_de  (video_de),
        .video_rgb (video_rgb)
    );

    initial begin
        pixel_clk = 1'b0;
        forever #5 pixel_clk = ~pixel_clk;  // 100 MHz sim clock
    end

    always @(posedge pixel_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: two frames did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // ******************************
    // compare tasks
    // ******************************
    task automatic check_rgb(input string name, input ppu_video_pkg::rgb888_t got,
                             input ppu_video_pkg::rgb888_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED %0t %s: got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED %0t %s: got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        checks++;
        if (got != want) begin
            errors++;
            $display("FAILED %0t %s: got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    a;
        int    b;
        int    v;
        string line;
        fd = $fopen("verif/ppu_video_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the vectors file verif/ppu_video_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "W %d %d %h", a, b, v) == 3)
                    w_rec.push_back({a[7:0], b[7:0], v[5:0]});
                else if ($sscanf(line, "C %d %d %h", a, b, v) == 3)
                    exp_rgb[b * `PPU_H_DISP + a] = v[23:0];
                else if (line.getc(0) != 8'h23) begin  // not a comment line
                    errors++;
                    $display("vectors file has a line that is not a record: %s", line);
                end
            end
            $fclose(fd);
        end
    endtask

    // ******************************
    // raster monitor, negedge
    // ******************************
    task automatic track_raster();
        int key;
        if (!reset_done) begin  // first cycle after reset
            check_bit("video_de", video_de, 1'b0);
            check_bit("video_hs", video_hs, 1'b0);
            check_bit("video_vs", video_vs, 1'b0);
            reset_done = 1'b1;
        end
        if (hs_prev && !video_hs) begin  // new line
            check_count("line length", line_cyc, `PPU_H_TOTAL);
            line_cyc = 0;
        end
        if (!hs_prev && video_hs) begin
            check_count("video_hs low clocks", hs_low, `PPU_H_SYNC);
            hs_low = 0;
        end
        if (vs_prev && !video_vs) begin  // new frame
            check_count("frame length", frame_cyc, FRAME_CYCLES);
            check_count("active lines per frame", de_row, `PPU_V_DISP);
            frame_cyc = 0;
            de_row = 0;
            frames++;
        end
        if (!vs_prev && video_vs) begin
            check_count("video_vs low clocks", vs_low, `PPU_V_SYNC * `PPU_H_TOTAL);
            vs_low = 0;
        end
        if (video_de) begin
            key = de_row * `PPU_H_DISP + de_x;
            if (exp_rgb.exists(key)) begin
                check_rgb($sformatf("video_rgb (%0d,%0d)", de_x, de_row), video_rgb,
                          exp_rgb[key]);
                c_hits++;
            end
            de_x++;
        end else begin
            check_rgb("video_rgb in blanking", video_rgb, '0);
            if (de_prev) begin  // end of an active line
                check_count("video_de clocks per line", de_x, `PPU_H_DISP);
                de_x = 0;
                de_row++;
            end
        end
        line_cyc++;
        frame_cyc++;
        if (!video_hs)
            hs_low++;
        if (!video_vs)
            vs_low++;
        hs_prev = video_hs;
        vs_prev = video_vs;
        de_prev = video_de;
    endtask

    always @(negedge pixel_clk) begin
        if (mon_on)
            track_raster();
    end

    initial begin
        sys_rst_n = 1'b0;
        ppu_we    = 1'b0;
        ppu_x     = '0;
        ppu_y     = '0;
        ppu_color = '0;
        load_vectors();
        repeat (8) @(posedge pixel_clk);
        sys_rst_n <= 1'b1;
        mon_on = 1'b1;
        foreach (w_rec[i]) begin  // one write per clock, still in vertical blank
            @(posedge pixel_clk);
            ppu_we <= 1'b1;
            {ppu_x, ppu_y, ppu_color} <= w_rec[i];
        end
        @(posedge pixel_clk);
        ppu_we <= 1'b0;
        wait (frames == 2);
        if (exp_rgb.num() == 0 || c_hits != 2 * exp_rgb.num()) begin
            errors++;
            $display("only %0d of %0d expected pixel checks were reached",
                     c_hits, 2 * exp_rgb.num());
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* verif/ppu_video_vectors.txt */
# W nes_x nes_y index(hex)      frame buffer write, applied in order
# C scr_x scr_y rgb888(hex)     expected screen pixel, checked in two frames
W 0 0 00
W 1 0 16
W 2 0 00
W 2 0 28
W 127 119 01
W 128 120 2A
W 200 10 21
W 255 239 30
C 0 0 002010
C 63 0 002010
C 64 0 787C78
C 65 1 787C78
C 66 0 F83800
C 68 1 F8B800
C 465 20 38BCF8
C 319 239 0000F8
C 320 240 58D850
C 574 478 F8FCF8
C 575 479 F8FCF8
C 576 479 002010
C 639 240 002010

/* ppu_video.f */
+incdir+include
source/ppu_video_pkg.sv
source/pixel_bus_if.sv
source/nes_palette.sv
source/ppu_frame_buffer.sv
source/ppu_pixel_fetch.sv
source/ppu_video_driver.sv
source/ppu_video_top.sv
verif/tb_ppu_video.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ppu_video
FILELIST  ?= ppu_video.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
